/* hdl/sem_params.svh */
`ifndef SEM_PARAMS_SVH
`define SEM_PARAMS_SVH

////////////////////////////////////////////////////////////
// Monitor stream window
////////////////////////////////////////////////////////////

// Characters held for pattern matching, newest at index 0
`define SEM_WINDOW_CHARS 9
// Hex digits after "PA " or "LA "
`define SEM_FAR_DIGITS 6
// Fill value of the window out of reset
`define SEM_BLANK_CHAR 8'h20

////////////////////////////////////////////////////////////
// Command FIFO
////////////////////////////////////////////////////////////

`define SEM_CMD_FIFO_DEPTH 16
// Pointer width, log2 of depth
`define SEM_CMD_PTR_W 4

`endif

/* hdl/sem_pkg.sv */
package sem_pkg;

	////////////////////////////////////////////////////////////
	// Shared types of the SEM user logic
	////////////////////////////////////////////////////////////

	// One ASCII monitor character or command byte
	typedef logic [7:0] char_t;

	// Frame address, six hex digits
	typedef logic [23:0] far_t;

	// Wrapping error counter
	typedef logic [7:0] err_cnt_t;

	// Core state bits, LSB first:
	// init, observation, correction, classification,
	// injection, essential, uncorrectable
	typedef logic [6:0] core_status_t;

	// Status register word toward the JTAG side
	typedef logic [15:0] status_word_t;

endpackage

/* hdl/sem_monitor_decoder.sv */
`include "sem_params.svh"

module sem_monitor_decoder
	import sem_pkg::*;
(
	input  logic  CLK40,
	input  logic  RST,
	input  char_t monitor_txdata,   // Character from the core
	input  logic  monitor_txwrite,  // One-cycle write strobe
	output logic  sed_pulse,        // New "SED" seen
	output logic  ded_pulse,        // New "DED" seen
	output logic  pa_load,          // Load physical address
	output logic  la_load,          // Load linear address
	output far_t  far_value         // Converted address, valid with the loads
);

	////////////////////////////////////////////////////////////
	// Character window
	////////////////////////////////////////////////////////////

	char_t [`SEM_WINDOW_CHARS-1:0] window; // Index 0 is newest

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			window <= {`SEM_WINDOW_CHARS{`SEM_BLANK_CHAR}}; // All blanks
		end else if (monitor_txwrite) begin
			window <= {window[`SEM_WINDOW_CHARS-2:0], monitor_txdata}; // Shift in
		end
	end

	////////////////////////////////////////////////////////////
	// Pattern match and edge detect
	////////////////////////////////////////////////////////////

	logic sed_match;
	logic ded_match;
	logic pa_match;
	logic la_match;
	logic sed_match_q;
	logic ded_match_q;
	logic pa_match_q;
	logic la_match_q;
	logic pa_rise;
	logic la_rise;

	// Error reports end in the newest three characters
	assign sed_match = (window[2:0] == "SED");
	assign ded_match = (window[2:0] == "DED");
	// Address tag sits in the oldest three, digits follow it
	assign pa_match = (window[`SEM_WINDOW_CHARS-1 -: 3] == "PA ");
	assign la_match = (window[`SEM_WINDOW_CHARS-1 -: 3] == "LA ");

	// Rising edge only, a held match counts once
	assign sed_pulse = sed_match & ~sed_match_q;
	assign ded_pulse = ded_match & ~ded_match_q;
	assign pa_rise   = pa_match & ~pa_match_q;
	assign la_rise   = la_match & ~la_match_q;

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sed_match_q <= 1'b0;
			ded_match_q <= 1'b0;
			pa_match_q  <= 1'b0;
			la_match_q  <= 1'b0;
			pa_load     <= 1'b0;
			la_load     <= 1'b0;
		end else begin
			sed_match_q <= sed_match;
			ded_match_q <= ded_match;
			pa_match_q  <= pa_match;
			la_match_q  <= la_match;
			pa_load     <= pa_rise; // One stage behind the match
			la_load     <= la_rise;
		end
	end

	////////////////////////////////////////////////////////////
	// Hex conversion of the address digits
	////////////////////////////////////////////////////////////

	far_t conv;

	// Low nibble as is, letters get +9 ('A' = 0x41 -> 0xA)
	always_comb begin
		conv = '0;
		for (int i = 0; i < `SEM_FAR_DIGITS; i++) begin
			conv[4*i +: 4] = window[i][6] ? window[i][3:0] + 4'd9 : window[i][3:0];
		end
	end

	// Captured only on a tag edge so later characters leave it alone
	always_ff @(posedge CLK40) begin
		if (pa_rise | la_rise) begin
			far_value <= conv;
		end
	end

endmodule

/* hdl/sem_far_capture.sv */
module sem_far_capture
	import sem_pkg::*;
(
	input  logic CLK40,
	input  logic RST,
	input  logic pa_load,       // Strobe from the decoder
	input  logic la_load,       // Strobe from the decoder
	input  far_t far_value,     // Address paired with the strobes
	input  logic jtag_ded_rst,  // Clear level from JTAG
	output far_t sem_far_pa,    // Physical frame address
	output far_t sem_far_la     // Linear frame address
);

	////////////////////////////////////////////////////////////
	// Physical address
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sem_far_pa <= '0;
		end else if (pa_load) begin
			sem_far_pa <= far_value; // Load wins over clear
		end else if (jtag_ded_rst) begin
			sem_far_pa <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Linear address
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sem_far_la <= '0;
		end else if (la_load) begin
			sem_far_la <= far_value;
		end else if (jtag_ded_rst) begin
			// Cleared together with the DED flag
			sem_far_la <= '0;
		end
	end

endmodule

/* hdl/sem_error_tracker.sv */
module sem_error_tracker
	import sem_pkg::*;
(
	input  logic         CLK40,
	input  logic         RST,
	input  logic         sed_pulse,       // Single error report
	input  logic         ded_pulse,       // Double error report
	input  logic         jtag_rst_cntrs,  // Counter clear level
	input  logic         jtag_ded_rst,    // Flag clear level
	input  core_status_t core_status,     // Core state bits
	input  logic         fecc_crcerr,     // Frame ECC CRC error
	output err_cnt_t     sngl_cnt,
	output err_cnt_t     dbl_cnt,
	output logic         dbl_err_det,     // Sticky double error
	output status_word_t sem_status
);

	////////////////////////////////////////////////////////////
	// Error counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sngl_cnt <= '0;
			dbl_cnt  <= '0;
		end else if (jtag_rst_cntrs) begin
			sngl_cnt <= '0; // Clear beats a pending count
			dbl_cnt  <= '0;
		end else begin
			if (sed_pulse) begin
				sngl_cnt <= sngl_cnt + 8'd1; // Wraps past 255
			end
			if (ded_pulse) begin
				dbl_cnt <= dbl_cnt + 8'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Double error flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			dbl_err_det <= 1'b0;
		end else if (jtag_ded_rst) begin
			dbl_err_det <= 1'b0; // Clear has priority
		end else if (ded_pulse) begin
			dbl_err_det <= 1'b1;
		end
	end

	// Status word
	// [6:0] core state, [7] spare, [8] CRC error, [9] DED, rest zero
	assign sem_status = {6'b0, dbl_err_det, fecc_crcerr, 1'b0, core_status};

endmodule

/* hdl/sem_cmd_fifo.sv */
`include "sem_params.svh"

module sem_cmd_fifo
	import sem_pkg::*;
(
	input  logic  CLK40,
	input  logic  RST,
	input  logic  jtag_send_cmd,    // Write strobe
	input  char_t jtag_cmd_data,    // Command byte
	input  logic  monitor_rxread,   // Pop from the core
	output char_t monitor_rxdata,   // Head of the FIFO
	output logic  monitor_rxempty
);

	////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////

	char_t mem [`SEM_CMD_FIFO_DEPTH];

	logic [`SEM_CMD_PTR_W-1:0] wr_ptr;
	logic [`SEM_CMD_PTR_W-1:0] rd_ptr;
	logic [`SEM_CMD_PTR_W:0]   fill_cnt;  // 0 to depth
	logic                      wr_en;
	logic                      rd_en;

	// Full drops the write, empty ignores the read
	assign wr_en = jtag_send_cmd & (fill_cnt != `SEM_CMD_FIFO_DEPTH);
	assign rd_en = monitor_rxread & (fill_cnt != 0);

	always_ff @(posedge CLK40) begin
		if (wr_en) begin
			mem[wr_ptr] <= jtag_cmd_data;
		end
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill_cnt <= '0;
		end else begin
			if (wr_en) begin
				if (wr_ptr == `SEM_CMD_PTR_W'(`SEM_CMD_FIFO_DEPTH - 1)) begin
					wr_ptr <= '0; // Circular
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (rd_en) begin
				if (rd_ptr == `SEM_CMD_PTR_W'(`SEM_CMD_FIFO_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Occupancy, push and pop together cancel
			case ({wr_en, rd_en})
				2'b10:   fill_cnt <= fill_cnt + 1'b1;
				2'b01:   fill_cnt <= fill_cnt - 1'b1;
				default: fill_cnt <= fill_cnt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read side, first word falls through
	////////////////////////////////////////////////////////////

	assign monitor_rxdata  = mem[rd_ptr];
	assign monitor_rxempty = (fill_cnt == 0);

endmodule

/* hdl/sem_monitor.sv */
module sem_monitor
	import sem_pkg::*;
(
	input  logic         CLK40,
	input  logic         RST,
	// Mitigation core monitor port
	input  char_t        monitor_txdata,
	input  logic         monitor_txwrite,
	input  logic         monitor_rxread,
	output char_t        monitor_rxdata,
	output logic         monitor_rxempty,
	// Core state and frame ECC
	input  core_status_t core_status,
	input  logic         fecc_crcerr,
	// JTAG register side
	input  logic         jtag_ded_rst,
	input  logic         jtag_rst_cntrs,
	input  logic         jtag_send_cmd,
	input  char_t        jtag_cmd_data,
	output far_t         sem_far_pa,
	output far_t         sem_far_la,
	output logic [15:0]  sem_errcnt,   // {dbl, sngl}
	output status_word_t sem_status
);

	////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////

	logic sed_pulse;
	logic ded_pulse;
	logic pa_load;
	logic la_load;
	far_t far_value;
	logic dbl_err_det;   // Also carried in sem_status bit 9

	sem_monitor_decoder decoder_i (
		.CLK40           (CLK40),
		.RST             (RST),
		.monitor_txdata  (monitor_txdata),
		.monitor_txwrite (monitor_txwrite),
		.sed_pulse       (sed_pulse),
		.ded_pulse       (ded_pulse),
		.pa_load         (pa_load),
		.la_load         (la_load),
		.far_value       (far_value)
	);

	sem_error_tracker tracker_i (
		.CLK40          (CLK40),
		.RST            (RST),
		.sed_pulse      (sed_pulse),
		.ded_pulse      (ded_pulse),
		.jtag_rst_cntrs (jtag_rst_cntrs),
		.jtag_ded_rst   (jtag_ded_rst),
		.core_status    (core_status),
		.fecc_crcerr    (fecc_crcerr),
		.sngl_cnt       (sem_errcnt[7:0]),   // Low byte
		.dbl_cnt        (sem_errcnt[15:8]),  // High byte
		.dbl_err_det    (dbl_err_det),
		.sem_status     (sem_status)
	);

	sem_far_capture capture_i (
		.CLK40        (CLK40),
		.RST          (RST),
		.pa_load      (pa_load),
		.la_load      (la_load),
		.far_value    (far_value),
		.jtag_ded_rst (jtag_ded_rst),
		.sem_far_pa   (sem_far_pa),
		.sem_far_la   (sem_far_la)
	);

	// Commands from JTAG into the core rx port
	sem_cmd_fifo cmd_fifo_i (
		.CLK40           (CLK40),
		.RST             (RST),
		.jtag_send_cmd   (jtag_send_cmd),
		.jtag_cmd_data   (jtag_cmd_data),
		.monitor_rxread  (monitor_rxread),
		.monitor_rxdata  (monitor_rxdata),
		.monitor_rxempty (monitor_rxempty)
	);

endmodule

/* verif/sem_monitor_props.sv */
`include "sem_params.svh"

module sem_monitor_props (
	input logic                    CLK40,
	input logic                    RST,
	input logic                    monitor_txwrite,  // Stream write strobe
	input logic                    sed_pulse,
	input logic                    ded_pulse,
	input logic                    pa_load,
	input logic                    la_load,
	input logic                    pa_match,         // Decoder tag match, before edge detect
	input logic                    la_match,
	input logic                    monitor_rxempty,
	input logic [`SEM_CMD_PTR_W:0] fill_cnt          // FIFO occupancy
);
	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////
	// Decoder
	////////////////////////////////////////////////////////////

	sed_ded_exclusive: assert property (@(posedge CLK40) disable iff (RST)
		!(sed_pulse && ded_pulse))
		else $error("sed_pulse and ded_pulse high in the same cycle");

	// Load strobe one stage behind its match, two behind the write that made it
	pa_load_after_match: assert property (@(posedge CLK40) disable iff (RST)
		pa_load |-> $past(pa_match) && $past(monitor_txwrite, 2))
		else $error("pa_load without a preceding PA match");

	la_load_after_match: assert property (@(posedge CLK40) disable iff (RST)
		la_load |-> $past(la_match) && $past(monitor_txwrite, 2))
		else $error("la_load without a preceding LA match");

	////////////////////////////////////////////////////////////
	// Command FIFO
	////////////////////////////////////////////////////////////

	rxempty_after_reset: assert property (@(posedge CLK40) RST |=> monitor_rxempty)
		else $error("monitor_rxempty low right after reset");

	fill_within_depth: assert property (@(posedge CLK40) disable iff (RST)
		fill_cnt <= `SEM_CMD_FIFO_DEPTH)
		else $error("FIFO occupancy above its depth");

endmodule

bind sem_monitor sem_monitor_props props_i (
	.CLK40           (CLK40),
	.RST             (RST),
	.monitor_txwrite (monitor_txwrite),
	.sed_pulse       (sed_pulse),
	.ded_pulse       (ded_pulse),
	.pa_load         (pa_load),
	.la_load         (la_load),
	.pa_match        (decoder_i.pa_match),
	.la_match        (decoder_i.la_match),
	.monitor_rxempty (monitor_rxempty),
	.fill_cnt        (cmd_fifo_i.fill_cnt)
);

/* verif/sem_monitor_tb.sv */
`include "sem_params.svh"

module sem_monitor_tb
	import sem_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS       = 5;
	localparam int CHARS_PER_TEST  = 3200;  // Upper bound, characters or FIFO steps
	localparam int WATCHDOG_CYCLES = NUM_TESTS * CHARS_PER_TEST * 8 + 2000;

	logic         CLK40;
	logic         RST;
	char_t        monitor_txdata;
	logic         monitor_txwrite;
	logic         monitor_rxread;
	char_t        monitor_rxdata;
	logic         monitor_rxempty;
	core_status_t core_status;
	logic         fecc_crcerr;
	logic         jtag_ded_rst;
	logic         jtag_rst_cntrs;
	logic         jtag_send_cmd;
	char_t        jtag_cmd_data;
	far_t         sem_far_pa;
	far_t         sem_far_la;
	logic [15:0]  sem_errcnt;
	status_word_t sem_status;

	// Reference model
	char_t    m_win [`SEM_WINDOW_CHARS];  // Index 0 newest, like the DUT window
	err_cnt_t m_sngl;
	err_cnt_t m_dbl;
	logic     m_ded;
	far_t     m_pa;
	far_t     m_la;
	char_t    m_fifo [$];
	int       tot_sed = 0;  // Unwrapped totals
	int       tot_ded = 0;

	logic [31:0] lcg_state = 32'd50;
	string       cur_test;
	int          check_cnt = 0;
	int          err_cnt = 0;
	int          test_err_base = 0;
	int          tests_failed = 0;

	sem_monitor dut_i (.*);

	initial begin
		CLK40 = 1'b0;
		forever #2 CLK40 = ~CLK40;  // 4 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK40);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Random numbers and characters
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg_next() >> 16) % n;  // Upper bits, better period
	endfunction

	// Letters of the tags on purpose, so stray matches happen
	function automatic char_t filler_char();
		string alphabet = "SEDPLA 0123456789ABCDEF.";
		return alphabet[rand_below(alphabet.len())];
	endfunction

	function automatic char_t hex_char(input int unsigned v);
		return (v < 10) ? char_t'(8'h30 + v) : char_t'(8'h37 + v);  // '0'..'9', 'A'..'F'
	endfunction

	////////////////////////////////////////////////////////////
	// Model of the decoder, counters and FIFO
	////////////////////////////////////////////////////////////

	function automatic void model_reset();
		for (int i = 0; i < `SEM_WINDOW_CHARS; i++) m_win[i] = `SEM_BLANK_CHAR;
		m_sngl = '0;
		m_dbl  = '0;
		m_ded  = 1'b0;
		m_pa   = '0;
		m_la   = '0;
		m_fifo.delete();
	endfunction

	function automatic logic tag_at(input int hi, input char_t a, input char_t b, input char_t c);
		return (m_win[hi] == a) && (m_win[hi-1] == b) && (m_win[hi-2] == c);
	endfunction

	// One nibble per digit, letters are low nibble plus nine
	function automatic far_t model_conv();
		far_t       r;
		logic [3:0] nib;
		r = '0;
		for (int i = 0; i < `SEM_FAR_DIGITS; i++) begin
			nib = m_win[i][3:0];
			if (m_win[i][6]) nib = nib + 4'd9;
			r[4*i +: 4] = nib;
		end
		return r;
	endfunction

	function automatic void model_push(input char_t c);
		logic sed_was;
		logic ded_was;
		logic pa_was;
		logic la_was;
		int   top;
		top     = `SEM_WINDOW_CHARS - 1;
		sed_was = tag_at(2, "S", "E", "D");
		ded_was = tag_at(2, "D", "E", "D");
		pa_was  = tag_at(top, "P", "A", " ");
		la_was  = tag_at(top, "L", "A", " ");
		for (int i = top; i > 0; i--) m_win[i] = m_win[i-1];
		m_win[0] = c;
		if (tag_at(2, "S", "E", "D") && !sed_was) begin  // Only a new match counts
			m_sngl = m_sngl + 8'd1;
			tot_sed++;
		end
		if (tag_at(2, "D", "E", "D") && !ded_was) begin
			m_dbl = m_dbl + 8'd1;
			m_ded = 1'b1;
			tot_ded++;
		end
		if (tag_at(top, "P", "A", " ") && !pa_was) m_pa = model_conv();
		if (tag_at(top, "L", "A", " ") && !la_was) m_la = model_conv();
	endfunction

	// Full FIFO drops the write, empty FIFO ignores the read
	function automatic void fifo_step(input logic wr, input logic rd, input char_t data);
		logic do_wr;
		logic do_rd;
		do_wr = wr && (m_fifo.size() < `SEM_CMD_FIFO_DEPTH);
		do_rd = rd && (m_fifo.size() > 0);
		if (do_rd) void'(m_fifo.pop_front());
		if (do_wr) m_fifo.push_back(data);
	endfunction

	////////////////////////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////////////////////////

	task automatic put_char(input char_t c);
		@(posedge CLK40);
		monitor_txdata  <= c;
		monitor_txwrite <= 1'b1;
		model_push(c);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK40);
			monitor_txwrite <= 1'b0;
			monitor_rxread  <= 1'b0;
			jtag_send_cmd   <= 1'b0;
			jtag_rst_cntrs  <= 1'b0;
			jtag_ded_rst    <= 1'b0;
		end
	endtask

	task automatic check_val(input string item, input logic [31:0] expected,
			input logic [31:0] actual);
		check_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("FAILED %s %s: expected %0h, actual %0h", cur_test, item, expected, actual);
		end
	endtask

	// Sampled mid-cycle, away from the active edge
	task automatic check_state();
		status_word_t exp_status;
		@(negedge CLK40);
		exp_status      = '0;
		exp_status[6:0] = core_status;
		exp_status[8]   = fecc_crcerr;
		exp_status[9]   = m_ded;
		check_val("sngl_cnt", 32'(m_sngl), 32'(sem_errcnt[7:0]));
		check_val("dbl_cnt", 32'(m_dbl), 32'(sem_errcnt[15:8]));
		check_val("sem_status", 32'(exp_status), 32'(sem_status));
		check_val("sem_far_pa", 32'(m_pa), 32'(sem_far_pa));
		check_val("sem_far_la", 32'(m_la), 32'(sem_far_la));
		check_val("monitor_rxempty", 32'(m_fifo.size() == 0), 32'(monitor_rxempty));
		if (m_fifo.size() > 0) begin
			check_val("monitor_rxdata", 32'(m_fifo[0]), 32'(monitor_rxdata));
		end
	endtask

	task automatic start_test(input string name);
		cur_test      = name;
		test_err_base = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err_base) begin
			$display("Test %s: done, no mismatches", cur_test);
		end else begin
			tests_failed++;
			$display("Test %s: done, %0d mismatches", cur_test, err_cnt - test_err_base);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic run_count_test();
		int unsigned nfill;
		start_test("error_counts");
		for (int m = 0; m < 640; m++) begin
			nfill = rand_below(3);
			repeat (nfill) put_char(filler_char());
			put_char((rand_below(2) == 0) ? "S" : "D");
			put_char("E");
			put_char("D");
			if (rand_below(4) == 0) idle_cycles(1 + rand_below(3));  // Match held, no recount
			if (m % 40 == 39) begin
				idle_cycles(4);
				check_state();
			end
		end
		if (tot_sed < 256 || tot_ded < 256) begin
			err_cnt++;
			$display("Stimulus too short, the error counters never wrapped past 255");
		end
		@(posedge CLK40);
		jtag_rst_cntrs <= 1'b1;
		m_sngl = '0;
		m_dbl  = '0;
		idle_cycles(4);
		check_state();
		end_test();
	endtask

	task automatic run_address_test();
		start_test("frame_address");
		for (int m = 0; m < 120; m++) begin
			put_char((rand_below(2) == 0) ? "P" : "L");
			put_char("A");
			put_char(" ");
			repeat (`SEM_FAR_DIGITS) put_char(hex_char(rand_below(16)));
			if (rand_below(2) == 0) begin  // Otherwise the next tag follows back to back
				idle_cycles(4);
				check_state();
			end
		end
		idle_cycles(4);
		check_state();
		end_test();
	endtask

	task automatic run_status_test();
		start_test("status_word");
		repeat (16) begin
			@(posedge CLK40);
			core_status <= core_status_t'(rand_below(128));
			fecc_crcerr <= (rand_below(2) != 0);
			idle_cycles(4);
			check_state();
		end
		@(posedge CLK40);
		jtag_ded_rst <= 1'b1;  // Clears flag and both addresses
		m_ded = 1'b0;
		m_pa  = '0;
		m_la  = '0;
		idle_cycles(4);
		check_state();
		// Flag is clear here, so a new DED has to set it
		put_char("D");
		put_char("E");
		put_char("D");
		idle_cycles(4);
		check_state();
		check_val("dbl_err_det set", 32'd1, 32'(sem_status[9]));
		end_test();
	endtask

	task automatic run_fifo_test();
		logic  wr;
		logic  rd;
		char_t data;
		start_test("command_fifo");
		for (int b = 0; b < 160; b++) begin
			repeat (1 + rand_below(6)) begin
				wr   = rand_below(4) < ((b < 80) ? 3 : 1);  // Mostly writes, then mostly reads
				rd   = rand_below(4) < ((b < 80) ? 1 : 3);
				data = char_t'(rand_below(256));
				@(posedge CLK40);
				jtag_send_cmd  <= wr;
				jtag_cmd_data  <= data;
				monitor_rxread <= rd;
				fifo_step(wr, rd, data);
			end
			idle_cycles(4);
			check_state();
		end
		// Overfill by four
		repeat (`SEM_CMD_FIFO_DEPTH + 4) begin
			data = char_t'(rand_below(256));
			@(posedge CLK40);
			jtag_send_cmd <= 1'b1;
			jtag_cmd_data <= data;
			fifo_step(1'b1, 1'b0, data);
		end
		idle_cycles(4);
		check_state();
		// Drain in order, last pop hits an empty FIFO
		repeat (`SEM_CMD_FIFO_DEPTH + 1) begin
			@(posedge CLK40);
			monitor_rxread <= 1'b1;
			fifo_step(1'b0, 1'b1, '0);
			idle_cycles(4);
			check_state();
		end
		end_test();
	endtask

	initial begin
		RST             <= 1'b1;
		monitor_txdata  <= '0;
		monitor_txwrite <= 1'b0;
		monitor_rxread  <= 1'b0;
		core_status     <= '0;
		fecc_crcerr     <= 1'b0;
		jtag_ded_rst    <= 1'b0;
		jtag_rst_cntrs  <= 1'b0;
		jtag_send_cmd   <= 1'b0;
		jtag_cmd_data   <= '0;
		model_reset();
		repeat (8) @(posedge CLK40);
		RST <= 1'b0;
		idle_cycles(4);
		start_test("reset_values");
		check_state();
		end_test();
		run_count_test();
		run_address_test();
		run_status_test();
		run_fifo_test();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/sem_pkg.sv
hdl/sem_monitor_decoder.sv
hdl/sem_far_capture.sv
hdl/sem_error_tracker.sv
hdl/sem_cmd_fifo.sv
hdl/sem_monitor.sv
verif/sem_monitor_props.sv
verif/sem_monitor_tb.sv

/* Makefile */
TOP := sem_monitor_tb

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
